// File: logic/dnc_read_settings.svh
// DNC read interface loader settings for widths, memory depth and region bases
`ifndef DNC_READ_SETTINGS_SVH
`define DNC_READ_SETTINGS_SVH

// Word width of keys, strengths and size inputs
`define DNC_DATA_SIZE 16

// Interface memory geometry
`define DNC_ADDR_SIZE 8
`define DNC_MEM_DEPTH 256

// Region bases inside the interface memory
// Key region holds up to MAX_R x MAX_W words
`define DNC_KEYS_BASE 8'd0
`define DNC_STRENGTHS_BASE 8'd192

// Largest legal sizes accepted from the host
`define DNC_MAX_R 8
`define DNC_MAX_W 16

`endif

// File: logic/dnc_read_pkg.sv
// DNC read interface package with loader states, arbiter clients and memory requests
`include "dnc_read_settings.svh"

package dnc_read_pkg;

  //////////////////////////////
  // Loader control
  //////////////////////////////

  // Shared by key and strength loaders
  typedef enum logic {
    IDLE = 1'b0,
    LOAD = 1'b1
  } loader_state_e;

  //////////////////////////////
  // Arbiter clients
  //////////////////////////////

  // One client per loader on the shared write port
  typedef enum logic {
    KEYS      = 1'b0,
    STRENGTHS = 1'b1
  } client_e;

  //////////////////////////////
  // Memory write request
  //////////////////////////////

  // Valid, address and data of one word write
  // 1 + 8 + 16 bits
  typedef struct packed {
    logic                      valid;
    logic [`DNC_ADDR_SIZE-1:0] addr;
    logic [`DNC_DATA_SIZE-1:0] data;
  } mem_req_t;

endpackage

// File: logic/dnc_read_keys.sv
// DNC read key loader walking the i/k loop, echoing keys and writing them to memory
`timescale 1ns/1ps
`include "dnc_read_settings.svh"

module dnc_read_keys import dnc_read_pkg::*; (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      START,
  input  logic [`DNC_DATA_SIZE-1:0] SIZE_R_IN,
  input  logic [`DNC_DATA_SIZE-1:0] SIZE_W_IN,
  input  logic [`DNC_DATA_SIZE-1:0] K_IN,
  input  logic                      K_IN_I_ENABLE,
  input  logic                      K_IN_K_ENABLE,
  input  logic                      GRANT,
  output logic [`DNC_DATA_SIZE-1:0] K_OUT,
  output logic                      K_OUT_I_ENABLE,
  output logic                      K_OUT_K_ENABLE,
  output logic                      READY,
  output mem_req_t                  REQ
);

  //////////////////////////////
  // Signals
  //////////////////////////////

  loader_state_e             state;

  // Sizes latched at START
  logic [`DNC_DATA_SIZE-1:0] size_r;
  logic [`DNC_DATA_SIZE-1:0] size_w;

  // Row and column of the next element
  logic [`DNC_DATA_SIZE-1:0] index_i;
  logic [`DNC_DATA_SIZE-1:0] index_k;

  logic                      last_col;
  logic                      last_row;
  logic                      key_strobe;
  logic [`DNC_DATA_SIZE-1:0] key_offset;

  // Pending write
  logic                      req_valid;
  logic [`DNC_ADDR_SIZE-1:0] req_addr;

  //////////////////////////////
  // Loop position
  //////////////////////////////

  assign last_col   = (index_k == size_w - 1'b1);
  assign last_row   = (index_i == size_r - 1'b1);
  assign key_strobe = (state == LOAD) && K_IN_K_ENABLE;

  // Row-major offset i*W + k
  assign key_offset = index_i * size_w + index_k;

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state          <= IDLE;
      size_r         <= '0;
      size_w         <= '0;
      index_i        <= '0;
      index_k        <= '0;
      K_OUT_I_ENABLE <= 1'b0;
      K_OUT_K_ENABLE <= 1'b0;
      READY          <= 1'b0;
      req_valid      <= 1'b0;
    end else begin
      // Single-cycle strobes by default
      READY          <= 1'b0;
      K_OUT_I_ENABLE <= 1'b0;
      K_OUT_K_ENABLE <= 1'b0;
      // Granted write leaves the slot
      if (GRANT) begin
        req_valid <= 1'b0;
      end
      case (state)
        IDLE: begin
          if (START) begin
            size_r  <= SIZE_R_IN;
            size_w  <= SIZE_W_IN;
            index_i <= '0;
            index_k <= '0;
            state   <= LOAD;
          end
        end
        LOAD: begin
          if (K_IN_K_ENABLE) begin
            // Echo and queue the element
            K_OUT_K_ENABLE <= 1'b1;
            K_OUT_I_ENABLE <= K_IN_I_ENABLE;
            req_valid      <= 1'b1;
            if (last_col) begin
              index_k <= '0;
              if (last_row) begin
                // Element (R-1, W-1) done
                READY <= 1'b1;
                state <= IDLE;
              end else begin
                index_i <= index_i + 1'b1;
              end
            end else begin
              index_k <= index_k + 1'b1;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  //////////////////////////////
  // Payload
  //////////////////////////////

  // Echo register doubles as write data
  always_ff @(posedge CLK) begin
    if (key_strobe) begin
      K_OUT    <= K_IN;
      req_addr <= `DNC_KEYS_BASE + key_offset[`DNC_ADDR_SIZE-1:0];
    end
  end

  assign REQ = '{valid: req_valid, addr: req_addr, data: K_OUT};

endmodule

// File: logic/dnc_read_strengths.sv
// DNC read strength loader walking the i loop, echoing strengths and writing them to memory
`timescale 1ns/1ps
`include "dnc_read_settings.svh"

module dnc_read_strengths import dnc_read_pkg::*; (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      START,
  input  logic [`DNC_DATA_SIZE-1:0] SIZE_R_IN,
  input  logic [`DNC_DATA_SIZE-1:0] S_IN,
  input  logic                      S_IN_ENABLE,
  input  logic                      GRANT,
  output logic [`DNC_DATA_SIZE-1:0] S_OUT,
  output logic                      S_OUT_ENABLE,
  output logic                      READY,
  output mem_req_t                  REQ
);

  //////////////////////////////
  // Signals
  //////////////////////////////

  loader_state_e             state;
  logic [`DNC_DATA_SIZE-1:0] size_r;
  logic [`DNC_DATA_SIZE-1:0] index_i;
  logic                      strength_strobe;

  // Pending write
  logic                      req_valid;
  logic [`DNC_ADDR_SIZE-1:0] req_addr;

  assign strength_strobe = (state == LOAD) && S_IN_ENABLE;

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= IDLE;
      size_r       <= '0;
      index_i      <= '0;
      S_OUT_ENABLE <= 1'b0;
      READY        <= 1'b0;
      req_valid    <= 1'b0;
    end else begin
      READY        <= 1'b0;
      S_OUT_ENABLE <= 1'b0;
      if (GRANT) begin
        req_valid <= 1'b0;
      end
      case (state)
        IDLE: begin
          if (START) begin
            size_r  <= SIZE_R_IN;
            index_i <= '0;
            state   <= LOAD;
          end
        end
        LOAD: begin
          if (S_IN_ENABLE) begin
            S_OUT_ENABLE <= 1'b1;
            req_valid    <= 1'b1;
            // Last head strength ends the run
            if (index_i == size_r - 1'b1) begin
              READY <= 1'b1;
              state <= IDLE;
            end else begin
              index_i <= index_i + 1'b1;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  //////////////////////////////
  // Payload
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (strength_strobe) begin
      S_OUT    <= S_IN;
      req_addr <= `DNC_STRENGTHS_BASE + index_i[`DNC_ADDR_SIZE-1:0];
    end
  end

  assign REQ = '{valid: req_valid, addr: req_addr, data: S_OUT};

endmodule

// File: logic/dnc_read_arbiter.sv
// DNC read round-robin arbiter sharing the memory write port between both loaders
`timescale 1ns/1ps

module dnc_read_arbiter import dnc_read_pkg::*; (
  input  logic     CLK,
  input  logic     RST,
  input  mem_req_t KEYS_REQ,
  input  mem_req_t STRENGTHS_REQ,
  output logic     KEYS_GRANT,
  output logic     STRENGTHS_GRANT,
  output mem_req_t MEM_REQ
);

  //////////////////////////////
  // Signals
  //////////////////////////////

  // Client granted most recently
  client_e last_grant;
  logic    keys_wins;

  //////////////////////////////
  // Grant selection
  //////////////////////////////

  // Keys win when alone or when strengths went last
  assign keys_wins = KEYS_REQ.valid &&
                     (!STRENGTHS_REQ.valid || (last_grant == STRENGTHS));

  assign KEYS_GRANT      = keys_wins;
  assign STRENGTHS_GRANT = STRENGTHS_REQ.valid && !keys_wins;

  // Winner's request onto the write port
  always_comb begin
    if (keys_wins) begin
      MEM_REQ = KEYS_REQ;
    end else begin
      MEM_REQ = STRENGTHS_REQ;
    end
    // Idle port when nobody asks
    MEM_REQ.valid = KEYS_GRANT || STRENGTHS_GRANT;
  end

  //////////////////////////////
  // Round-robin pointer
  //////////////////////////////

  // Starts on strengths so keys go first
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      last_grant <= STRENGTHS;
    end else if (KEYS_GRANT) begin
      last_grant <= KEYS;
    end else if (STRENGTHS_GRANT) begin
      last_grant <= STRENGTHS;
    end
  end

endmodule

// File: logic/dnc_read_memory.sv
// DNC read interface memory with one write port and one registered read port
`timescale 1ns/1ps
`include "dnc_read_settings.svh"

module dnc_read_memory import dnc_read_pkg::*; (
  input  logic                      CLK,
  input  mem_req_t                  WR,
  input  logic [`DNC_ADDR_SIZE-1:0] RD_ADDR,
  output logic [`DNC_DATA_SIZE-1:0] RD_DATA
);

  //////////////////////////////
  // Storage
  //////////////////////////////

  // Keys low, strengths from their base upward
  logic [`DNC_DATA_SIZE-1:0] mem [0:`DNC_MEM_DEPTH-1];

  // Write on the edge after the granted request
  always_ff @(posedge CLK) begin
    if (WR.valid) begin
      mem[WR.addr] <= WR.data;
    end
  end

  // Registered read, one cycle latency
  always_ff @(posedge CLK) begin
    RD_DATA <= mem[RD_ADDR];
  end

endmodule

// File: logic/dnc_read_interface.sv
// DNC read interface top joining key and strength loaders, write arbiter and memory
`timescale 1ns/1ps
`include "dnc_read_settings.svh"

module dnc_read_interface import dnc_read_pkg::*; (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      START,
  input  logic [`DNC_DATA_SIZE-1:0] SIZE_R_IN,
  input  logic [`DNC_DATA_SIZE-1:0] SIZE_W_IN,
  // Key stream
  input  logic                      K_IN_I_ENABLE,
  input  logic                      K_IN_K_ENABLE,
  input  logic [`DNC_DATA_SIZE-1:0] K_IN,
  output logic                      K_OUT_I_ENABLE,
  output logic                      K_OUT_K_ENABLE,
  output logic [`DNC_DATA_SIZE-1:0] K_OUT,
  output logic                      K_READY,
  // Strength stream
  input  logic                      S_IN_ENABLE,
  input  logic [`DNC_DATA_SIZE-1:0] S_IN,
  output logic                      S_OUT_ENABLE,
  output logic [`DNC_DATA_SIZE-1:0] S_OUT,
  output logic                      S_READY,
  // Readback
  input  logic [`DNC_ADDR_SIZE-1:0] RD_ADDR,
  output logic [`DNC_DATA_SIZE-1:0] RD_DATA
);

  //////////////////////////////
  // Write path
  //////////////////////////////

  mem_req_t keys_req;
  mem_req_t strengths_req;
  mem_req_t mem_req;
  logic     keys_grant;
  logic     strengths_grant;

  // Key loader, k(t;i;k)
  dnc_read_keys keys (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .SIZE_R_IN      (SIZE_R_IN),
    .SIZE_W_IN      (SIZE_W_IN),
    .K_IN           (K_IN),
    .K_IN_I_ENABLE  (K_IN_I_ENABLE),
    .K_IN_K_ENABLE  (K_IN_K_ENABLE),
    .GRANT          (keys_grant),
    .K_OUT          (K_OUT),
    .K_OUT_I_ENABLE (K_OUT_I_ENABLE),
    .K_OUT_K_ENABLE (K_OUT_K_ENABLE),
    .READY          (K_READY),
    .REQ            (keys_req)
  );

  // Strength loader, beta(t;i)
  dnc_read_strengths strengths (
    .CLK          (CLK),
    .RST          (RST),
    .START        (START),
    .SIZE_R_IN    (SIZE_R_IN),
    .S_IN         (S_IN),
    .S_IN_ENABLE  (S_IN_ENABLE),
    .GRANT        (strengths_grant),
    .S_OUT        (S_OUT),
    .S_OUT_ENABLE (S_OUT_ENABLE),
    .READY        (S_READY),
    .REQ          (strengths_req)
  );

  dnc_read_arbiter arbiter (
    .CLK             (CLK),
    .RST             (RST),
    .KEYS_REQ        (keys_req),
    .STRENGTHS_REQ   (strengths_req),
    .KEYS_GRANT      (keys_grant),
    .STRENGTHS_GRANT (strengths_grant),
    .MEM_REQ         (mem_req)
  );

  dnc_read_memory memory (
    .CLK     (CLK),
    .WR      (mem_req),
    .RD_ADDR (RD_ADDR),
    .RD_DATA (RD_DATA)
  );

endmodule

// File: dv/dnc_read_checker.sv
// DNC read checker on write-port arbitration, strobe spacing and READY pulses
`timescale 1ns/1ps

module dnc_read_checker import dnc_read_pkg::*; (
  input logic    CLK,
  input logic    RST,
  input logic    keys_valid,
  input logic    keys_grant,
  input logic    keys_strobe,
  input logic    keys_ready,
  input logic    strengths_valid,
  input logic    strengths_grant,
  input logic    strengths_strobe,
  input logic    strengths_ready,
  input client_e last_grant
);

  // Running count of failed assertions
  int unsigned fail_count = 0;

  //////////////////////////////
  // Arbiter
  //////////////////////////////

  // One write per cycle
  grant_exclusive: assert property (@(posedge CLK) disable iff (RST)
    !(keys_grant && strengths_grant))
    else begin
      $error("Both loaders granted in the same cycle");
      fail_count++;
    end

  // No grant without a pending request
  keys_grant_valid: assert property (@(posedge CLK) disable iff (RST)
    keys_grant |-> keys_valid)
    else begin
      $error("Key loader granted with no pending request");
      fail_count++;
    end

  strengths_grant_valid: assert property (@(posedge CLK) disable iff (RST)
    strengths_grant |-> strengths_valid)
    else begin
      $error("Strength loader granted with no pending request");
      fail_count++;
    end

  // Contention goes to the client not granted last
  round_robin: assert property (@(posedge CLK) disable iff (RST)
    (keys_valid && strengths_valid) |->
      ((last_grant == STRENGTHS) ? keys_grant : strengths_grant))
    else begin
      $error("Round-robin order broken under contention");
      fail_count++;
    end

  // Pending slot drains within 2 cycles
  keys_drain: assert property (@(posedge CLK) disable iff (RST)
    (keys_valid && !keys_grant) |=> keys_grant)
    else begin
      $error("Key request pending for more than 2 cycles");
      fail_count++;
    end

  strengths_drain: assert property (@(posedge CLK) disable iff (RST)
    (strengths_valid && !strengths_grant) |=> strengths_grant)
    else begin
      $error("Strength request pending for more than 2 cycles");
      fail_count++;
    end

  //////////////////////////////
  // Loaders
  //////////////////////////////

  // New strobe only onto a free or draining slot
  keys_spacing: assert property (@(posedge CLK) disable iff (RST)
    (keys_strobe && keys_valid) |-> keys_grant)
    else begin
      $error("Key strobe arrived while a request was still pending");
      fail_count++;
    end

  strengths_spacing: assert property (@(posedge CLK) disable iff (RST)
    (strengths_strobe && strengths_valid) |-> strengths_grant)
    else begin
      $error("Strength strobe arrived while a request was still pending");
      fail_count++;
    end

  keys_ready_pulse: assert property (@(posedge CLK) disable iff (RST)
    keys_ready |=> !keys_ready)
    else begin
      $error("K_READY held longer than one cycle");
      fail_count++;
    end

  strengths_ready_pulse: assert property (@(posedge CLK) disable iff (RST)
    strengths_ready |=> !strengths_ready)
    else begin
      $error("S_READY held longer than one cycle");
      fail_count++;
    end

endmodule

// Top-level attach point, sees the arbiter and both loaders
bind dnc_read_interface dnc_read_checker read_checks (
  .CLK              (CLK),
  .RST              (RST),
  .keys_valid       (keys_req.valid),
  .keys_grant       (keys_grant),
  .keys_strobe      (K_IN_K_ENABLE),
  .keys_ready       (K_READY),
  .strengths_valid  (strengths_req.valid),
  .strengths_grant  (strengths_grant),
  .strengths_strobe (S_IN_ENABLE),
  .strengths_ready  (S_READY),
  .last_grant       (arbiter.last_grant)
);

// File: dv/dnc_read_tb.sv
// DNC read interface testbench with LCG stimulus, memory image model and echo checks
`timescale 1ns/1ps
`include "dnc_read_settings.svh"

module dnc_read_tb;

  localparam int PASSES      = 8;
  localparam int CYCLE_LIMIT = 6000;

  //////////////////////////////
  // DUT signals
  //////////////////////////////

  logic                      CLK;
  logic                      RST;
  logic                      START;
  logic [`DNC_DATA_SIZE-1:0] SIZE_R_IN;
  logic [`DNC_DATA_SIZE-1:0] SIZE_W_IN;
  logic                      K_IN_I_ENABLE;
  logic                      K_IN_K_ENABLE;
  logic [`DNC_DATA_SIZE-1:0] K_IN;
  logic                      K_OUT_I_ENABLE;
  logic                      K_OUT_K_ENABLE;
  logic [`DNC_DATA_SIZE-1:0] K_OUT;
  logic                      K_READY;
  logic                      S_IN_ENABLE;
  logic [`DNC_DATA_SIZE-1:0] S_IN;
  logic                      S_OUT_ENABLE;
  logic [`DNC_DATA_SIZE-1:0] S_OUT;
  logic                      S_READY;
  logic [`DNC_ADDR_SIZE-1:0] RD_ADDR;
  logic [`DNC_DATA_SIZE-1:0] RD_DATA;

  //////////////////////////////
  // Model state
  //////////////////////////////

  logic [31:0]               rand_state = 32'ha951;
  int unsigned               cycle_count = 0;
  logic [`DNC_DATA_SIZE-1:0] mem_model [0:`DNC_MEM_DEPTH-1];
  // Expected key echoes as {first of row, data}
  logic [`DNC_DATA_SIZE:0]   key_echo_q [$];
  logic [`DNC_DATA_SIZE-1:0] strength_echo_q [$];
  // What was driven on the previous falling edge
  logic                      key_strobe_prev = 1'b0;
  logic                      key_last_prev = 1'b0;
  logic                      strength_strobe_prev = 1'b0;
  logic                      strength_last_prev = 1'b0;
  logic                      key_ready_seen;
  logic                      strength_ready_seen;

  dnc_read_interface UUT (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .SIZE_R_IN      (SIZE_R_IN),
    .SIZE_W_IN      (SIZE_W_IN),
    .K_IN_I_ENABLE  (K_IN_I_ENABLE),
    .K_IN_K_ENABLE  (K_IN_K_ENABLE),
    .K_IN           (K_IN),
    .K_OUT_I_ENABLE (K_OUT_I_ENABLE),
    .K_OUT_K_ENABLE (K_OUT_K_ENABLE),
    .K_OUT          (K_OUT),
    .K_READY        (K_READY),
    .S_IN_ENABLE    (S_IN_ENABLE),
    .S_IN           (S_IN),
    .S_OUT_ENABLE   (S_OUT_ENABLE),
    .S_OUT          (S_OUT),
    .S_READY        (S_READY),
    .RD_ADDR        (RD_ADDR),
    .RD_DATA        (RD_DATA)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  // LCG step, value in [0, range)
  function automatic int unsigned next_random(input int unsigned range);
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return (rand_state >> 8) % range;
  endfunction

  // Outputs seen now against inputs of the previous falling edge
  task automatic check_outputs();
    logic [`DNC_DATA_SIZE:0]   key_exp;
    logic [`DNC_DATA_SIZE-1:0] strength_exp;
    assert (K_OUT_K_ENABLE === key_strobe_prev) else report_failure($sformatf(
      "Mismatch K_OUT_K_ENABLE: got %h expected %h", K_OUT_K_ENABLE, key_strobe_prev));
    assert (S_OUT_ENABLE === strength_strobe_prev) else report_failure($sformatf(
      "Mismatch S_OUT_ENABLE: got %h expected %h", S_OUT_ENABLE, strength_strobe_prev));
    assert (K_READY === key_last_prev) else report_failure($sformatf(
      "Mismatch K_READY: got %h expected %h", K_READY, key_last_prev));
    assert (S_READY === strength_last_prev) else report_failure($sformatf(
      "Mismatch S_READY: got %h expected %h", S_READY, strength_last_prev));
    key_exp = '0;
    if (key_strobe_prev) begin
      key_exp = key_echo_q.pop_front();
      assert (K_OUT === key_exp[`DNC_DATA_SIZE-1:0]) else report_failure($sformatf(
        "Mismatch K_OUT: got %h expected %h", K_OUT, key_exp[`DNC_DATA_SIZE-1:0]));
    end
    // First-of-row flag only with a key echo
    assert (K_OUT_I_ENABLE === key_exp[`DNC_DATA_SIZE]) else report_failure($sformatf(
      "Mismatch K_OUT_I_ENABLE: got %h expected %h", K_OUT_I_ENABLE,
      key_exp[`DNC_DATA_SIZE]));
    if (strength_strobe_prev) begin
      strength_exp = strength_echo_q.pop_front();
      assert (S_OUT === strength_exp) else report_failure($sformatf(
        "Mismatch S_OUT: got %h expected %h", S_OUT, strength_exp));
    end
    if (K_READY) key_ready_seen = 1'b1;
    if (S_READY) strength_ready_seen = 1'b1;
    // Protocol properties of the bound checker
    assert (UUT.read_checks.fail_count == 0) else report_failure(
      "Protocol assertion failed in the bound checker");
  endtask

  task automatic clear_strobes();
    K_IN_K_ENABLE        = 1'b0;
    K_IN_I_ENABLE        = 1'b0;
    S_IN_ENABLE          = 1'b0;
    key_strobe_prev      = 1'b0;
    key_last_prev        = 1'b0;
    strength_strobe_prev = 1'b0;
    strength_last_prev   = 1'b0;
  endtask

  task automatic read_and_compare(input int addr);
    RD_ADDR = addr[`DNC_ADDR_SIZE-1:0];
    @(negedge CLK);
    check_outputs();
    assert (RD_DATA === mem_model[addr]) else report_failure($sformatf(
      "Mismatch RD_DATA at %h: got %h expected %h", addr, RD_DATA, mem_model[addr]));
  endtask

  //////////////////////////////
  // One load pass
  //////////////////////////////

  task automatic run_pass(input int size_r, input int size_w);
    int                        key_i;
    int                        key_k;
    int                        key_count;
    int                        strength_count;
    int                        key_wait;
    int                        strength_wait;
    logic [`DNC_DATA_SIZE-1:0] data;
    key_i = 0;
    key_k = 0;
    key_count = 0;
    strength_count = 0;
    key_ready_seen = 1'b0;
    strength_ready_seen = 1'b0;
    SIZE_R_IN = size_r;
    SIZE_W_IN = size_w;
    START = 1'b1;
    @(negedge CLK);
    check_outputs();
    START = 1'b0;
    key_wait = next_random(3);
    strength_wait = next_random(3);
    // Both streams interleaved, each with gaps of 2 to 4 cycles
    while (!(key_ready_seen && strength_ready_seen)) begin
      clear_strobes();
      if (key_count < size_r * size_w) begin
        if (key_wait == 0) begin
          data = next_random(65536);
          K_IN = data;
          K_IN_K_ENABLE = 1'b1;
          K_IN_I_ENABLE = (key_k == 0);
          key_echo_q.push_back({(key_k == 0), data});
          mem_model[`DNC_KEYS_BASE + key_i * size_w + key_k] = data;
          key_strobe_prev = 1'b1;
          key_count++;
          key_last_prev = (key_count == size_r * size_w);
          // k first, wrap into the next row
          if (key_k == size_w - 1) begin
            key_k = 0;
            key_i++;
          end else begin
            key_k++;
          end
          key_wait = 1 + next_random(3);
        end else begin
          key_wait--;
        end
      end
      if (strength_count < size_r) begin
        if (strength_wait == 0) begin
          data = next_random(65536);
          S_IN = data;
          S_IN_ENABLE = 1'b1;
          strength_echo_q.push_back(data);
          mem_model[`DNC_STRENGTHS_BASE + strength_count] = data;
          strength_strobe_prev = 1'b1;
          strength_count++;
          strength_last_prev = (strength_count == size_r);
          strength_wait = 1 + next_random(3);
        end else begin
          strength_wait--;
        end
      end
      @(negedge CLK);
      check_outputs();
    end
    clear_strobes();
    // Let the last writes land
    repeat (4) begin
      @(negedge CLK);
      check_outputs();
    end
    for (int a = 0; a < size_r * size_w; a++) begin
      read_and_compare(`DNC_KEYS_BASE + a);
    end
    for (int a = 0; a < size_r; a++) begin
      read_and_compare(`DNC_STRENGTHS_BASE + a);
    end
  endtask

  //////////////////////////////
  // Sequence
  //////////////////////////////

  initial begin
    int size_r;
    int size_w;
    RST = 1'b1;
    START = 1'b0;
    SIZE_R_IN = '0;
    SIZE_W_IN = '0;
    K_IN = '0;
    S_IN = '0;
    RD_ADDR = '0;
    clear_strobes();
    repeat (3) @(negedge CLK);
    RST = 1'b0;
    // Quiet outputs before any START
    repeat (3) begin
      @(negedge CLK);
      check_outputs();
    end
    for (int pass = 0; pass < PASSES; pass++) begin
      case (pass)
        0: begin
          size_r = 1;
          size_w = 1;
        end
        1: begin
          size_r = `DNC_MAX_R;
          size_w = `DNC_MAX_W;
        end
        2: begin
          size_r = 1;
          size_w = 1 + next_random(`DNC_MAX_W);
        end
        3: begin
          size_r = 1 + next_random(`DNC_MAX_R);
          size_w = 1;
        end
        default: begin
          size_r = 1 + next_random(`DNC_MAX_R);
          size_w = 1 + next_random(`DNC_MAX_W);
        end
      endcase
      run_pass(size_r, size_w);
    end
    $display("Test passed");
    $finish;
  end

  // Run limit
  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    assert (cycle_count < CYCLE_LIMIT) else report_failure($sformatf(
      "Timeout: run did not finish within %0d cycles", CYCLE_LIMIT));
  end

endmodule

// File: bender.yml
package:
  name: dnc_read_interface

sources:
  # Design
  - include_dirs:
      - logic
    files:
      - logic/dnc_read_pkg.sv
      - logic/dnc_read_keys.sv
      - logic/dnc_read_strengths.sv
      - logic/dnc_read_arbiter.sv
      - logic/dnc_read_memory.sv
      - logic/dnc_read_interface.sv

  # Verification
  - target: simulation
    include_dirs:
      - logic
    files:
      - dv/dnc_read_checker.sv
      - dv/dnc_read_tb.sv

// File: filelist.f
+incdir+logic
logic/dnc_read_pkg.sv
logic/dnc_read_keys.sv
logic/dnc_read_strengths.sv
logic/dnc_read_arbiter.sv
logic/dnc_read_memory.sv
logic/dnc_read_interface.sv
dv/dnc_read_checker.sv
dv/dnc_read_tb.sv
